//--- bench/cuRefModel.svh
`ifndef CU_REF_MODEL_SVH
`define CU_REF_MODEL_SVH

typedef cuPkg::ctrlWordT wordQueueT[$];

// Fetch1 word, ROM read alone
function automatic cuPkg::ctrlWordT fetchWord();
    cuPkg::ctrlWordT w;
    w = cuPkg::ctrlIdle;
    w.iromRead = 1'b1;
    return w;
endfunction

function automatic cuPkg::ctrlWordT fetch2Word();
    cuPkg::ctrlWordT w;
    w = cuPkg::ctrlIdle;
    w.regWrite.ir = 1'b1;
    w.incMask.pc = 1'b1;                                 // Step past opcode byte
    return w;
endfunction

// Memory access word, or the strobe-only word of a hold cycle
function automatic cuPkg::ctrlWordT memWord(input logic write, input logic held);
    cuPkg::ctrlWordT w;
    w = cuPkg::ctrlIdle;
    w.memRead = !write;
    w.memWrite = write;
    if (!held) begin
        w.busSel = write ? cuPkg::busDr : cuPkg::busMem;
    end
    return w;
endfunction

// DR loads the memory data
function automatic cuPkg::ctrlWordT drLoadWord();
    cuPkg::ctrlWordT w;
    w = cuPkg::ctrlIdle;
    w.regWrite.dr = 1'b1;
    w.busSel = cuPkg::busMem;
    return w;
endfunction

// Words of all states after Fetch3, holds included
function automatic wordQueueT refSequence(input cuPkg::instrT instr, input logic zFlag,
                                          input int memDelay, output logic endsCore);
    wordQueueT seq;
    cuPkg::ctrlWordT w;
    logic regOp;
    endsCore = 1'b0;
    regOp = 1'b0;
    w = cuPkg::ctrlIdle;
    case (instr.opcode)
        cuPkg::opJmp: begin
            if (instr.subOp inside {cuPkg::jmpM, cuPkg::jmpK, cuPkg::jmpN}) begin
                case (instr.subOp)
                    cuPkg::jmpM: w.compSel = cuPkg::compM;
                    cuPkg::jmpK: w.compSel = cuPkg::compK;
                    default:     w.compSel = cuPkg::compN;
                endcase
                seq.push_back(w);
                seq.push_back(cuPkg::ctrlIdle);              // Zero flag settles
                if (!zFlag) begin
                    seq.push_back(fetchWord());              // Target byte
                    w = cuPkg::ctrlIdle;
                    w.regWrite.ar = 1'b1;
                    w.selAr = 1'b1;
                    seq.push_back(w);
                    w = cuPkg::ctrlIdle;
                    w.regWrite.pc = 1'b1;
                    w.busSel = cuPkg::busAr;
                    seq.push_back(w);
                end else if (instr.subOp == cuPkg::jmpM) begin
                    seq.push_back(cuPkg::ctrlIdle);          // Program over
                    endsCore = 1'b1;
                end else begin
                    w = cuPkg::ctrlIdle;
                    w.incMask.pc = 1'b1;
                    seq.push_back(w);
                end
            end
        end
        cuPkg::opCopy: begin
            if (instr.subOp inside {[cuPkg::copyM:cuPkg::copyT]}) begin
                seq.push_back(fetchWord());
                w.regWrite.ar = 1'b1;
                w.selAr = 1'b1;
                w.incMask.pc = 1'b1;
                seq.push_back(w);
                if (instr.subOp == cuPkg::copyM || instr.subOp == cuPkg::copyT) begin
                    w = cuPkg::ctrlIdle;
                    w.coreIncAr = 1'b1;                      // Per-core address
                    seq.push_back(w);
                end
                seq.push_back(memWord(1'b0, 1'b0));
                repeat (memDelay) seq.push_back(memWord(1'b0, 1'b1));
                seq.push_back(drLoadWord());
                w = cuPkg::ctrlIdle;
                w.busSel = cuPkg::busDr;
                case (instr.subOp)
                    cuPkg::copyM: w.regWrite.rm1 = 1'b1;
                    cuPkg::copyK: w.regWrite.rk1 = 1'b1;
                    cuPkg::copyN: w.regWrite.rn1 = 1'b1;
                    cuPkg::copyR: w.regWrite.rr = 1'b1;
                    default:      w.regWrite.rt4 = 1'b1;
                endcase
                seq.push_back(w);
            end
        end
        cuPkg::opLoad: begin
            if (instr.subOp inside {cuPkg::loadC1, cuPkg::loadC2}) begin
                w.regWrite.ar = 1'b1;
                w.busSel = (instr.subOp == cuPkg::loadC1) ? cuPkg::busC1 : cuPkg::busC2;
                seq.push_back(w);
                seq.push_back(memWord(1'b0, 1'b0));
                repeat (memDelay) seq.push_back(memWord(1'b0, 1'b1));
                seq.push_back(drLoadWord());
            end
        end
        cuPkg::opStore: begin
            w.regWrite.dr = 1'b1;
            w.busSel = cuPkg::busRt;
            seq.push_back(w);
            w = cuPkg::ctrlIdle;
            w.regWrite.ar = 1'b1;
            w.busSel = cuPkg::busC3;
            seq.push_back(w);
            seq.push_back(memWord(1'b1, 1'b0));
            repeat (memDelay) seq.push_back(memWord(1'b1, 1'b1));
        end
        cuPkg::opReset: begin
            regOp = 1'b1;
            case (instr.subOp)
                cuPkg::resetAll: w.clrMask = '1;
                cuPkg::resetN2:  w.clrMask.rn2 = 1'b1;
                cuPkg::resetK2:  w.clrMask.rk2 = 1'b1;
                cuPkg::resetRt:  w.clrMask.rt = 1'b1;
                default:         regOp = 1'b0;
            endcase
        end
        cuPkg::opMove: begin
            regOp = 1'b1;
            w.busSel = cuPkg::busAc;
            case (instr.subOp)
                cuPkg::moveRp: w.regWrite.rp = 1'b1;
                cuPkg::moveRt: w.regWrite.rt = 1'b1;
                cuPkg::moveC1: w.regWrite.c1 = 1'b1;
                cuPkg::moveC3: w.regWrite.c3 = 1'b1;
                default:       regOp = 1'b0;
            endcase
        end
        cuPkg::opAdd: begin
            regOp = 1'b1;
            w.regWrite.ac = 1'b1;
            w.aluOp = cuPkg::aluAdd;
            case (instr.subOp)
                cuPkg::addRt: w.busSel = cuPkg::busRt;
                cuPkg::addRr: w.busSel = cuPkg::busRr;
                cuPkg::addM2: w.busSel = cuPkg::busRm2;
                cuPkg::addMem: begin
                    w.busSel = cuPkg::busC3;
                    w.aluOp = cuPkg::aluAddMem;
                end
                default: regOp = 1'b0;
            endcase
        end
        cuPkg::opInc: begin
            regOp = 1'b1;
            case (instr.subOp)
                cuPkg::incC2: w.incMask.c2 = 1'b1;
                cuPkg::incC3: w.incMask.c3 = 1'b1;
                cuPkg::incM2: w.incMask.rm2 = 1'b1;
                cuPkg::incK2: w.incMask.rk2 = 1'b1;
                cuPkg::incN2: w.incMask.rn2 = 1'b1;
                default:      regOp = 1'b0;
            endcase
        end
        cuPkg::opEnd: begin
            seq.push_back(cuPkg::ctrlIdle);
            endsCore = 1'b1;
        end
        default: seq = {};                                  // Straight back to fetch
    endcase
    if (regOp) begin
        seq.push_back(w);
    end
    return seq;
endfunction

`endif

//--- bench/controlUnitTb.sv
`timescale 1ns/1ps
`default_nettype none

module controlUnitTb;

    localparam int clkPeriod    = 4;
    localparam int resetCycles  = 5;
    localparam int randSeed     = 63921;
    localparam int fetchTimeout = 10;        // Cycles allowed to reach Fetch1
    localparam int parkCycles   = 20;

    logic            Clk;
    logic            reset;
    cuPkg::instrT    ins;
    logic            imemAv;
    logic            memAv;
    logic            z;
    cuPkg::ctrlWordT ctrl;
    logic            coreDone;

    string           testName;
    logic            checkOn;                // Enables the compare process
    cuPkg::ctrlWordT expWord;
    logic            expDone;

    `include "cuRefModel.svh"

    controlUnit u_controlUnit (
        .Clk      (Clk),
        .reset    (reset),
        .ins      (ins),
        .imemAv   (imemAv),
        .memAv    (memAv),
        .z        (z),
        .ctrl     (ctrl),
        .coreDone (coreDone)
    );

    initial begin
        Clk = 1'b0;
        forever #(clkPeriod / 2) Clk = ~Clk;
    end

    task automatic stopRun();
        $display("Finished with errors");
        $fatal(1);
    endtask

    task automatic checkWord(input string name, input cuPkg::ctrlWordT expected,
                             input cuPkg::ctrlWordT actual);
        if (actual !== expected) begin
            $display("Fail %s: ctrl expected %h, actual %h", name, expected, actual);
            stopRun();
        end
    endtask

    task automatic checkDone(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            $display("Fail %s: coreDone expected %b, actual %b", name, expected, actual);
            stopRun();
        end
    endtask

    // Outputs are settled by the falling edge
    always @(negedge Clk) begin
        if (checkOn) begin
            checkWord(testName, expWord, ctrl);
            checkDone(testName, expDone, coreDone);
        end
    end

    task automatic nextCycle();
        @(posedge Clk);
        #1;
    endtask

    task automatic setExpected(input cuPkg::ctrlWordT word, input logic done);
        expWord = word;
        expDone = done;
    endtask

    task automatic waitForFetch();
        int cycles;
        cycles = 0;
        while (ctrl !== fetchWord()) begin
            if (cycles == fetchTimeout) begin
                $display("The unit did not reach the fetch state after reset");
                stopRun();
            end else begin
                nextCycle();
                cycles++;
            end
        end
    endtask

    task automatic applyReset();
        checkOn = 1'b0;
        reset = 1'b1;
        imemAv = 1'b0;
        repeat (resetCycles) @(posedge Clk);
        #1;
        reset = 1'b0;
        waitForFetch();
    endtask

    // Starts in the first Fetch1 cycle and ends in the next one
    task automatic runInstr(input string name, input cuPkg::instrT instr, input logic zFlag,
                            input int memDelay, input int imemDelay);
        wordQueueT seq;
        logic endsCore;
        seq = refSequence(instr, zFlag, memDelay, endsCore);
        testName = name;
        checkOn = 1'b1;
        for (int i = 0; i <= imemDelay; i++) begin
            setExpected(fetchWord(), 1'b0);
            imemAv = (i == imemDelay);
            nextCycle();
        end
        setExpected(fetch2Word(), 1'b0);
        imemAv = 1'b0;
        nextCycle();
        setExpected(cuPkg::ctrlIdle, 1'b0);               // Fetch3, IR now valid
        ins = instr;
        z = zFlag;
        memAv = 1'b1;
        nextCycle();
        for (int j = 0; j < seq.size(); j++) begin
            setExpected(seq[j], endsCore && j == seq.size() - 1);
            // Ready flag is seen a cycle late, so drop it one cycle ahead
            memAv = !(j + 2 < seq.size() && (seq[j + 1].memRead || seq[j + 1].memWrite)
                      && (seq[j + 2].memRead || seq[j + 2].memWrite));
            nextCycle();
        end
        if (endsCore) begin
            for (int k = 0; k < parkCycles; k++) begin
                setExpected(cuPkg::ctrlIdle, 1'b1);
                nextCycle();
            end
        end
    endtask

    initial begin
        cuPkg::instrT instr;
        cuPkg::instrT memOps[$];
        int delay;
        int op;
        int sub;
        void'($urandom(randSeed));
        reset = 1'b1;
        ins = '0;
        imemAv = 1'b0;
        memAv = 1'b1;
        z = 1'b0;
        checkOn = 1'b0;
        expWord = cuPkg::ctrlIdle;
        expDone = 1'b0;
        testName = "reset";
        applyReset();
        checkWord("reset", fetchWord(), ctrl);
        checkDone("reset", 1'b0, coreDone);

        instr = '{opcode: cuPkg::opInc, subOp: cuPkg::incC2};
        runInstr("fetch wait", instr, 1'b0, 0, $urandom_range(4, 12));

        // Top sub-op values are unknown for most register ops
        repeat (40) begin
            op = cuPkg::opReset + $urandom_range(0, 3);
            sub = $urandom_range(0, 5);
            instr = cuPkg::instrT'({op[3:0], sub[3:0]});
            runInstr($sformatf("regop %h", instr), instr, 1'b0, 0, $urandom_range(0, 3));
        end
        for (op = 0; op < 16; op++) begin
            if (op == 0 || op > cuPkg::opEnd) begin
                instr = cuPkg::instrT'({op[3:0], 4'($urandom_range(0, 15))});
                runInstr($sformatf("unknown %h", instr), instr, 1'b0, 0, 0);
            end
        end

        for (sub = cuPkg::copyM; sub <= cuPkg::copyT; sub++) begin
            memOps.push_back(cuPkg::instrT'({cuPkg::opCopy, sub[3:0]}));
        end
        memOps.push_back(cuPkg::instrT'({cuPkg::opLoad, cuPkg::loadC1}));
        memOps.push_back(cuPkg::instrT'({cuPkg::opLoad, cuPkg::loadC2}));
        memOps.push_back(cuPkg::instrT'({cuPkg::opStore, 4'h0}));
        foreach (memOps[i]) begin
            for (int rep = 0; rep < 3; rep++) begin
                delay = (rep == 0) ? 0 : (rep == 1) ? 5 : $urandom_range(0, 5);
                runInstr($sformatf("memop %h delay %0d", memOps[i], delay), memOps[i],
                         1'b0, delay, $urandom_range(0, 2));
            end
        end

        for (sub = cuPkg::jmpM; sub <= cuPkg::jmpN; sub++) begin
            instr = cuPkg::instrT'({cuPkg::opJmp, sub[3:0]});
            runInstr($sformatf("jump %0d taken", sub), instr, 1'b0, 0, $urandom_range(0, 2));
            if (sub != cuPkg::jmpM) begin
                runInstr($sformatf("jump %0d skip", sub), instr, 1'b1, 0, 0);
            end
        end

        // Outer loop exhausted
        instr = '{opcode: cuPkg::opJmp, subOp: cuPkg::jmpM};
        runInstr("jump M end", instr, 1'b1, 0, 1);
        applyReset();
        checkDone("reset after end", 1'b0, coreDone);
        instr = '{opcode: cuPkg::opEnd, subOp: 4'h0};
        runInstr("end", instr, 1'b0, 0, 0);
        applyReset();
        instr = '{opcode: cuPkg::opAdd, subOp: cuPkg::addMem};
        runInstr("restart", instr, 1'b0, 0, 0);

        $display("Finished with no errors");
        $finish;
    end

endmodule

`default_nettype wire

//--- logic/controlUnit.sv
`timescale 1ns/1ps
`default_nettype none

module controlUnit (
    input  wire logic         Clk,
    input  wire logic         reset,
    input  wire cuPkg::instrT ins,           // From the external IR
    input  wire logic         imemAv,        // Instruction ROM has data
    input  wire logic         memAv,         // Data memory access complete
    input  wire logic         z,             // Comparator zero flag
    output cuPkg::ctrlWordT   ctrl,
    output logic              coreDone
);

    wire cuPkg::stateT execState;
    wire cuPkg::stateT nextState;

    instrDecoder u_instrDecoder (
        .ins       (ins),
        .execState (execState)
    );

    sequencer u_sequencer (
        .Clk       (Clk),
        .reset     (reset),
        .imemAv    (imemAv),
        .memAv     (memAv),
        .z         (z),
        .ins       (ins),
        .execState (execState),
        .state     (),
        .nextState (nextState),
        .coreDone  (coreDone)
    );

    // Registers the word of the state being entered
    controlWordGen u_controlWordGen (
        .Clk       (Clk),
        .reset     (reset),
        .nextState (nextState),
        .ins       (ins),
        .ctrl      (ctrl)
    );

endmodule

`default_nettype wire

//--- logic/controlWordGen.sv
`timescale 1ns/1ps
`default_nettype none

module controlWordGen (
    input  wire logic         Clk,
    input  wire logic         reset,
    input  wire cuPkg::stateT nextState,
    input  wire cuPkg::instrT ins,
    output cuPkg::ctrlWordT   ctrl           // Word of the current state
);

    cuPkg::ctrlWordT word;

    always_comb begin
        word = cuPkg::ctrlIdle;
        case (nextState)
            cuPkg::Fetch1: word.iromRead = 1'b1;
            cuPkg::Fetch2: begin
                word.regWrite.ir = 1'b1;
                word.incMask.pc  = 1'b1;
            end
            cuPkg::JmpCmp: begin
                case (ins.subOp)
                    cuPkg::jmpM: word.compSel = cuPkg::compM;
                    cuPkg::jmpK: word.compSel = cuPkg::compK;
                    cuPkg::jmpN: word.compSel = cuPkg::compN;
                    default:     word.compSel = cuPkg::compNone;
                endcase
            end
            cuPkg::JmpRead, cuPkg::CopyRead: word.iromRead = 1'b1;   // Address byte
            cuPkg::JmpLoadAr: begin
                word.regWrite.ar = 1'b1;
                word.selAr       = 1'b1;
            end
            cuPkg::JmpLoadPc: begin
                word.regWrite.pc = 1'b1;
                word.busSel      = cuPkg::busAr;
            end
            cuPkg::JmpSkip: word.incMask.pc = 1'b1;             // Step over address byte
            cuPkg::CopyLoadAr: begin
                word.regWrite.ar = 1'b1;
                word.selAr       = 1'b1;
                word.incMask.pc  = 1'b1;
            end
            cuPkg::CopyCoreOfs: word.coreIncAr = 1'b1;
            cuPkg::CopyMemRd, cuPkg::LoadMemRd: begin
                word.memRead = 1'b1;
                word.busSel  = cuPkg::busMem;
            end
            cuPkg::CopyLoadDr, cuPkg::LoadLoadDr: begin
                word.regWrite.dr = 1'b1;
                word.busSel      = cuPkg::busMem;
            end
            cuPkg::CopyWrite: begin
                word.busSel = cuPkg::busDr;
                case (ins.subOp)
                    cuPkg::copyM: word.regWrite.rm1 = 1'b1;
                    cuPkg::copyK: word.regWrite.rk1 = 1'b1;
                    cuPkg::copyN: word.regWrite.rn1 = 1'b1;
                    cuPkg::copyR: word.regWrite.rr  = 1'b1;
                    cuPkg::copyT: word.regWrite.rt4 = 1'b1;
                    default:      word.regWrite     = '0;
                endcase
            end
            cuPkg::LoadAddr: begin
                word.regWrite.ar = 1'b1;
                word.busSel = (ins.subOp == cuPkg::loadC2) ? cuPkg::busC2 : cuPkg::busC1;
            end
            cuPkg::StoreDr: begin
                word.regWrite.dr = 1'b1;                          // DR from RT
                word.busSel      = cuPkg::busRt;
            end
            cuPkg::StoreAddr: begin
                word.regWrite.ar = 1'b1;
                word.busSel      = cuPkg::busC3;
            end
            cuPkg::StoreMemWr: begin
                word.memWrite = 1'b1;
                word.busSel   = cuPkg::busDr;
            end
            // Keep the pending strobe so the request stays stable
            cuPkg::Hold: begin
                word.memRead  = ctrl.memRead;
                word.memWrite = ctrl.memWrite;
            end
            cuPkg::RegOp: begin
                case (ins.opcode)
                    cuPkg::opReset: begin
                        case (ins.subOp)
                            cuPkg::resetAll: word.clrMask     = '1;
                            cuPkg::resetN2:  word.clrMask.rn2 = 1'b1;
                            cuPkg::resetK2:  word.clrMask.rk2 = 1'b1;
                            cuPkg::resetRt:  word.clrMask.rt  = 1'b1;
                            default:         word.clrMask     = '0;
                        endcase
                    end
                    cuPkg::opMove: begin
                        word.busSel = cuPkg::busAc;
                        case (ins.subOp)
                            cuPkg::moveRp: word.regWrite.rp = 1'b1;
                            cuPkg::moveRt: word.regWrite.rt = 1'b1;
                            cuPkg::moveC1: word.regWrite.c1 = 1'b1;
                            cuPkg::moveC3: word.regWrite.c3 = 1'b1;
                            default:       word.regWrite    = '0;
                        endcase
                    end
                    cuPkg::opAdd: begin
                        word.regWrite.ac = 1'b1;                  // Result lands in AC
                        word.aluOp       = cuPkg::aluAdd;
                        case (ins.subOp)
                            cuPkg::addRt: word.busSel = cuPkg::busRt;
                            cuPkg::addRr: word.busSel = cuPkg::busRr;
                            cuPkg::addM2: word.busSel = cuPkg::busRm2;
                            default: begin
                                word.busSel = cuPkg::busC3;
                                word.aluOp  = cuPkg::aluAddMem;
                            end
                        endcase
                    end
                    cuPkg::opInc: begin
                        case (ins.subOp)
                            cuPkg::incC2: word.incMask.c2  = 1'b1;
                            cuPkg::incC3: word.incMask.c3  = 1'b1;
                            cuPkg::incM2: word.incMask.rm2 = 1'b1;
                            cuPkg::incK2: word.incMask.rk2 = 1'b1;
                            cuPkg::incN2: word.incMask.rn2 = 1'b1;
                            default:      word.incMask     = '0;
                        endcase
                    end
                    default: word = cuPkg::ctrlIdle;
                endcase
            end
            default: word = cuPkg::ctrlIdle;                      // Fetch3, JmpZero, EndOp
        endcase
    end

    always_ff @(posedge Clk) begin
        if (reset) begin
            ctrl <= cuPkg::ctrlFetch;
        end else begin
            ctrl <= word;
        end
    end

endmodule

`default_nettype wire

//--- logic/cuPkg.sv
`default_nettype none

package cuPkg;

    localparam int dataWidth = 8;               // Instruction width

    // Upper instruction nibble
    typedef enum logic [dataWidth/2-1:0] {
        opJmp   = 4'h1,
        opCopy  = 4'h2,
        opLoad  = 4'h3,
        opStore = 4'h4,
        opReset = 4'h5,
        opMove  = 4'h6,
        opAdd   = 4'h7,
        opInc   = 4'h8,
        opEnd   = 4'h9
    } opcodeT;

    typedef logic [dataWidth/2-1:0] subOpT;     // Meaning depends on opcode

    localparam subOpT jmpM     = 4'h0;          // Compare M1 with M2
    localparam subOpT jmpK     = 4'h1;
    localparam subOpT jmpN     = 4'h2;

    localparam subOpT copyM    = 4'h0;          // Target RM1, core offset applied
    localparam subOpT copyK    = 4'h1;
    localparam subOpT copyN    = 4'h2;
    localparam subOpT copyR    = 4'h3;
    localparam subOpT copyT    = 4'h4;          // Target RT4, core offset applied

    localparam subOpT loadC1   = 4'h0;
    localparam subOpT loadC2   = 4'h1;

    localparam subOpT resetAll = 4'h0;
    localparam subOpT resetN2  = 4'h1;
    localparam subOpT resetK2  = 4'h2;
    localparam subOpT resetRt  = 4'h3;

    // MOVE copies AC into the target
    localparam subOpT moveRp   = 4'h0;
    localparam subOpT moveRt   = 4'h1;
    localparam subOpT moveC1   = 4'h2;
    localparam subOpT moveC3   = 4'h3;

    localparam subOpT addRt    = 4'h0;
    localparam subOpT addRr    = 4'h1;
    localparam subOpT addM2    = 4'h2;
    localparam subOpT addMem   = 4'h3;          // AC plus C3 with memory offset

    localparam subOpT incC2    = 4'h0;
    localparam subOpT incC3    = 4'h1;
    localparam subOpT incM2    = 4'h2;
    localparam subOpT incK2    = 4'h3;
    localparam subOpT incN2    = 4'h4;

    typedef struct packed {
        opcodeT opcode;
        subOpT  subOp;
    } instrT;

    typedef enum logic [4:0] {
        Fetch1, Fetch2, Fetch3,
        JmpCmp, JmpZero, JmpRead, JmpLoadAr, JmpLoadPc, JmpSkip,
        CopyRead, CopyLoadAr, CopyCoreOfs, CopyMemRd, CopyLoadDr, CopyWrite,
        LoadAddr, LoadMemRd, LoadLoadDr,
        StoreDr, StoreAddr, StoreMemWr,
        Hold, RegOp, EndOp
    } stateT;

    // Register write enables, RT4 is bit 14 and AC bit 0
    typedef struct packed {
        logic rt4, rr, pc, ir, ar, dr, rp, rt;
        logic rm1, rk1, rn1, c1, c2, c3, ac;
    } regMaskT;

    typedef enum logic [4:0] {
        busNone = 5'd0,  busAc  = 5'd1,  busC3  = 5'd2,  busC2  = 5'd3,
        busC1   = 5'd4,  busRn2 = 5'd5,  busRk2 = 5'd6,  busRm2 = 5'd7,
        busRn1  = 5'd8,  busRk1 = 5'd9,  busRm1 = 5'd10, busRt  = 5'd11,
        busRp   = 5'd12, busDr  = 5'd13, busAr  = 5'd14, busMem = 5'd15,
        busRr   = 5'd16, busRt4 = 5'd17
    } busSrcT;

    typedef struct packed {
        logic pc, rm2, rk2, rn2, c2, c3;
    } incMaskT;

    typedef struct packed {
        logic rt, rm2, rk2, rn2, ac;
    } clrMaskT;

    // Both comparator muxes share this select
    typedef enum logic [2:0] {
        compNone = 3'b000,
        compN    = 3'b001,
        compK    = 3'b010,
        compM    = 3'b100
    } compSelT;

    typedef enum logic [3:0] {
        aluNone   = 4'b0000,
        aluAdd    = 4'b0100,
        aluAddMem = 4'b1000
    } aluOpT;

    typedef struct packed {
        logic    iromRead;
        logic    memRead;
        logic    memWrite;
        logic    selAr;                         // AR loads from instruction ROM
        logic    coreIncAr;                     // AR plus core ID
        regMaskT regWrite;
        busSrcT  busSel;
        incMaskT incMask;
        clrMaskT clrMask;
        compSelT compSel;
        aluOpT   aluOp;
    } ctrlWordT;

    localparam ctrlWordT ctrlIdle = '{
        iromRead: 1'b0, memRead: 1'b0, memWrite: 1'b0, selAr: 1'b0, coreIncAr: 1'b0,
        regWrite: '0, busSel: busNone, incMask: '0, clrMask: '0,
        compSel: compNone, aluOp: aluNone
    };

    // Word of Fetch1, also the word right after reset
    localparam ctrlWordT ctrlFetch = '{
        iromRead: 1'b1, memRead: 1'b0, memWrite: 1'b0, selAr: 1'b0, coreIncAr: 1'b0,
        regWrite: '0, busSel: busNone, incMask: '0, clrMask: '0,
        compSel: compNone, aluOp: aluNone
    };

endpackage

`default_nettype wire

//--- logic/instrDecoder.sv
`timescale 1ns/1ps
`default_nettype none

module instrDecoder (
    input  wire cuPkg::instrT ins,
    output cuPkg::stateT      execState      // First execute state after Fetch3
);

    always_comb begin
        execState = cuPkg::Fetch1;           // Unknown opcode or sub-op goes back to fetch
        case (ins.opcode)
            cuPkg::opJmp: begin
                if (ins.subOp inside {cuPkg::jmpM, cuPkg::jmpK, cuPkg::jmpN}) begin
                    execState = cuPkg::JmpCmp;
                end
            end
            cuPkg::opCopy: begin
                if (ins.subOp inside {cuPkg::copyM, cuPkg::copyK, cuPkg::copyN,
                                      cuPkg::copyR, cuPkg::copyT}) begin
                    execState = cuPkg::CopyRead;
                end
            end
            cuPkg::opLoad: begin
                if (ins.subOp inside {cuPkg::loadC1, cuPkg::loadC2}) begin
                    execState = cuPkg::LoadAddr;
                end
            end
            cuPkg::opStore: execState = cuPkg::StoreDr;     // No sub-op
            // Single cycle register ops
            cuPkg::opReset: begin
                if (ins.subOp inside {cuPkg::resetAll, cuPkg::resetN2,
                                      cuPkg::resetK2, cuPkg::resetRt}) begin
                    execState = cuPkg::RegOp;
                end
            end
            cuPkg::opMove: begin
                if (ins.subOp inside {cuPkg::moveRp, cuPkg::moveRt,
                                      cuPkg::moveC1, cuPkg::moveC3}) begin
                    execState = cuPkg::RegOp;
                end
            end
            cuPkg::opAdd: begin
                if (ins.subOp inside {cuPkg::addRt, cuPkg::addRr,
                                      cuPkg::addM2, cuPkg::addMem}) begin
                    execState = cuPkg::RegOp;
                end
            end
            cuPkg::opInc: begin
                if (ins.subOp inside {cuPkg::incC2, cuPkg::incC3, cuPkg::incM2,
                                      cuPkg::incK2, cuPkg::incN2}) begin
                    execState = cuPkg::RegOp;
                end
            end
            cuPkg::opEnd: execState = cuPkg::EndOp;
            default: execState = cuPkg::Fetch1;
        endcase
    end

endmodule

`default_nettype wire

//--- logic/sequencer.sv
`timescale 1ns/1ps
`default_nettype none

module sequencer (
    input  wire logic         Clk,
    input  wire logic         reset,
    input  wire logic         imemAv,
    input  wire logic         memAv,
    input  wire logic         z,
    input  wire cuPkg::instrT ins,
    input  wire cuPkg::stateT execState,
    output cuPkg::stateT      state,
    output cuPkg::stateT      nextState,
    output logic              coreDone
);

    logic         zReg;                      // Comparator flag, one cycle late
    logic         memAvReg;
    logic         jmpMFlag;                  // Current jump compares M1 with M2
    cuPkg::stateT heldState;                 // Memory state waiting in Hold
    cuPkg::stateT resumeState;

    // Continuation once the held memory access completes
    always_comb begin
        case (heldState)
            cuPkg::CopyMemRd: resumeState = cuPkg::CopyLoadDr;
            cuPkg::LoadMemRd: resumeState = cuPkg::LoadLoadDr;
            default:          resumeState = cuPkg::Fetch1;     // Store done
        endcase
    end

    always_comb begin
        nextState = cuPkg::Fetch1;
        case (state)
            cuPkg::Fetch1:     nextState = imemAv ? cuPkg::Fetch2 : cuPkg::Fetch1;
            cuPkg::Fetch2:     nextState = cuPkg::Fetch3;
            cuPkg::Fetch3:     nextState = execState;
            cuPkg::JmpCmp:     nextState = cuPkg::JmpZero;
            cuPkg::JmpZero: begin
                if (!zReg) begin
                    nextState = cuPkg::JmpRead;                   // Taken when pair differs
                end else if (jmpMFlag) begin
                    nextState = cuPkg::EndOp;                     // Outer loop finished
                end else begin
                    nextState = cuPkg::JmpSkip;
                end
            end
            cuPkg::JmpRead:    nextState = cuPkg::JmpLoadAr;
            cuPkg::JmpLoadAr:  nextState = cuPkg::JmpLoadPc;
            cuPkg::JmpLoadPc:  nextState = cuPkg::Fetch1;
            cuPkg::JmpSkip:    nextState = cuPkg::Fetch1;
            cuPkg::CopyRead:   nextState = cuPkg::CopyLoadAr;
            cuPkg::CopyLoadAr: begin
                // M and RT4 addresses are offset by the core ID
                if (ins.subOp == cuPkg::copyM || ins.subOp == cuPkg::copyT) begin
                    nextState = cuPkg::CopyCoreOfs;
                end else begin
                    nextState = cuPkg::CopyMemRd;
                end
            end
            cuPkg::CopyCoreOfs: nextState = cuPkg::CopyMemRd;
            cuPkg::CopyMemRd:  nextState = memAvReg ? cuPkg::CopyLoadDr : cuPkg::Hold;
            cuPkg::CopyLoadDr: nextState = cuPkg::CopyWrite;
            cuPkg::CopyWrite:  nextState = cuPkg::Fetch1;
            cuPkg::LoadAddr:   nextState = cuPkg::LoadMemRd;
            cuPkg::LoadMemRd:  nextState = memAvReg ? cuPkg::LoadLoadDr : cuPkg::Hold;
            cuPkg::LoadLoadDr: nextState = cuPkg::Fetch1;
            cuPkg::StoreDr:    nextState = cuPkg::StoreAddr;
            cuPkg::StoreAddr:  nextState = cuPkg::StoreMemWr;
            cuPkg::StoreMemWr: nextState = memAvReg ? cuPkg::Fetch1 : cuPkg::Hold;
            cuPkg::Hold:       nextState = memAvReg ? resumeState : cuPkg::Hold;
            cuPkg::RegOp:      nextState = cuPkg::Fetch1;
            cuPkg::EndOp:      nextState = cuPkg::EndOp;       // Parked until reset
            default:           nextState = cuPkg::Fetch1;
        endcase
    end

    always_ff @(posedge Clk) begin
        if (reset) begin
            state     <= cuPkg::Fetch1;
            zReg      <= 1'b0;
            memAvReg  <= 1'b0;
            jmpMFlag  <= 1'b0;
            heldState <= cuPkg::Fetch1;
            coreDone  <= 1'b0;
        end else begin
            state    <= nextState;
            zReg     <= z;
            memAvReg <= memAv;
            if (nextState == cuPkg::JmpCmp) begin
                jmpMFlag <= (ins.subOp == cuPkg::jmpM);
            end
            if (nextState == cuPkg::Hold && state != cuPkg::Hold) begin
                heldState <= state;
            end
            if (nextState == cuPkg::EndOp) begin
                coreDone <= 1'b1;                          // Sticky
            end
        end
    end

endmodule

`default_nettype wire

//--- project.f
+incdir+bench
logic/cuPkg.sv
logic/instrDecoder.sv
logic/sequencer.sv
logic/controlWordGen.sv
logic/controlUnit.sv
bench/controlUnitTb.sv
